//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = heapMemoryTb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/arrayBank.sv
/*
  One heap array: element storage and size, with bounds, full and empty
  checks for the element commands
*/
`include "heapMemory_macros.svh"

module arrayBank import heapMemoryPkg::*; (
  input  logic      clock,
  input  logic      resetN,
  input  logic      select,      // Element command targets this bank
  input  logic      clear,       // Array newly allocated
  input  heapOpT    opcode,
  input  indexT     index,
  input  dataT      dataIn,
  output dataT      bankResult,
  output heapErrorT bankFault
);

  dataT elements [`HEAP_ARRAY_LENGTH];
  sizeT size;

  dataT  element;        // Element at index
  sizeT  sizeDec;
  logic  inBounds;
  logic  isFull;
  logic  isEmpty;
  logic  writeEnable;
  indexT writeAddr;
  dataT  writeData;
  logic  sizeLoad;
  sizeT  sizeNext;

  assign element  = elements[index];
  assign sizeDec  = size - 1'b1;
  assign inBounds = sizeT'(index) < size;
  assign isFull   = size == sizeT'(`HEAP_ARRAY_LENGTH);
  assign isEmpty  = size == '0;

  // ------------------------------
  // Element command decode
  always_comb begin
    bankResult  = '0;
    bankFault   = ErrNone;
    writeEnable = 1'b0;
    writeAddr   = index;
    writeData   = dataIn;
    sizeLoad    = 1'b0;
    sizeNext    = size;
    if (select) begin
      case (opcode)
        Write: begin
          writeEnable = 1'b1;
          bankResult  = dataIn;
          if (!inBounds) begin                                 // Grow to cover index
            sizeLoad = 1'b1;
            sizeNext = sizeT'(index) + 1'b1;
          end
        end
        Size: bankResult = dataT'(size);
        Push: begin
          if (isFull) begin
            bankFault = ErrFull;
          end else begin
            writeEnable = 1'b1;
            writeAddr   = size[`HEAP_INDEX_WIDTH-1:0];         // Slot after last
            sizeLoad    = 1'b1;
            sizeNext    = size + 1'b1;
          end
        end
        Pop: begin
          if (isEmpty) begin
            bankFault = ErrEmpty;
          end else begin
            bankResult = elements[sizeDec[`HEAP_INDEX_WIDTH-1:0]];
            sizeLoad   = 1'b1;
            sizeNext   = sizeDec;
          end
        end
        default: begin                                         // Read, arithmetic, logic
          if (!inBounds) begin
            bankFault = ErrOutOfBounds;
          end else begin
            writeEnable = opcode != Read;
            case (opcode)
              Add, AddAfter:      writeData = element + dataIn;  // Wraps at width
              Subtract, SubAfter: writeData = element - dataIn;
              Or:                 writeData = element | dataIn;
              Xor:                writeData = element ^ dataIn;
              And:                writeData = element & dataIn;
              default:            writeData = element;
            endcase
            // After forms hand back the old value
            bankResult = (opcode == Read || opcode == AddAfter || opcode == SubAfter)
                         ? element : writeData;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) size <= '0;
    else if (clear) size <= '0;                                // Fresh array is empty
    else if (sizeLoad) size <= sizeNext;
  end

  always_ff @(posedge clock) begin
    if (writeEnable) elements[writeAddr] <= writeData;
  end

endmodule

//--- hdl/heapController.sv
/*
  Heap command controller: allocation bitmap, LIFO of freed ids and
  fresh-id counter; checks array ownership and selects the target bank
*/
`include "heapMemory_macros.svh"

module heapController import heapMemoryPkg::*; (
  input  logic                         clock,
  input  logic                         resetN,
  input  heapOpT                       opcode,
  input  arrayIdT                      arrayId,
  output logic [`HEAP_ARRAY_COUNT-1:0] bankSelect,  // Element command to bank
  output logic [`HEAP_ARRAY_COUNT-1:0] bankClear,   // Zero size of new array
  output arrayIdT                      selectedId,
  output dataT                         allocId,
  output heapErrorT                    ctrlFault
);

  logic [`HEAP_ARRAY_COUNT-1:0] allocated;                    // One bit per live array
  logic [`HEAP_ID_WIDTH:0]      nextFresh;                    // Next never-used id
  logic [`HEAP_ID_WIDTH:0]      stackTop;                     // Entries on free stack
  arrayIdT                      freeStack [`HEAP_ARRAY_COUNT];

  arrayIdT newId;        // Id handed out by Alloc
  arrayIdT popSlot;      // Top entry of free stack
  logic    allocOk;
  logic    freeOk;
  logic    fromStack;    // Reuse a freed id first
  logic    isAllocated;

  assign isAllocated = allocated[arrayId];
  assign selectedId  = arrayId;
  assign fromStack   = stackTop != '0;
  assign popSlot     = arrayIdT'(stackTop - 1'b1);

  // ------------------------------
  // Command decode
  always_comb begin
    bankSelect = '0;
    bankClear  = '0;
    ctrlFault  = ErrNone;
    allocOk    = 1'b0;
    freeOk     = 1'b0;
    newId      = '0;
    case (opcode)
      Nop: begin
      end
      Alloc: begin
        if (fromStack) begin
          newId   = freeStack[popSlot];                       // LIFO reuse
          allocOk = 1'b1;
        end else if (!nextFresh[`HEAP_ID_WIDTH]) begin        // Fresh ids left
          newId   = nextFresh[`HEAP_ID_WIDTH-1:0];
          allocOk = 1'b1;
        end else begin
          ctrlFault = ErrOutOfMemory;
        end
        bankClear[newId] = allocOk;
      end
      Free: begin
        if (isAllocated) freeOk = 1'b1;
        else ctrlFault = ErrNotAllocated;                     // Catches double free
      end
      default: begin                                          // Element commands
        if (isAllocated) bankSelect[arrayId] = 1'b1;
        else ctrlFault = ErrNotAllocated;
      end
    endcase
  end

  assign allocId = allocOk ? dataT'(newId) : '0;

  // ------------------------------
  // Allocation state
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      nextFresh <= '0;
      stackTop  <= '0;
    end else begin
      if (allocOk) begin
        allocated[newId] <= 1'b1;
        if (fromStack) stackTop <= stackTop - 1'b1;
        else nextFresh <= nextFresh + 1'b1;
      end
      if (freeOk) begin
        allocated[arrayId] <= 1'b0;
        stackTop           <= stackTop + 1'b1;
      end
    end
  end

  // Stack storage, never more entries than arrays
  always_ff @(posedge clock) begin
    if (freeOk) freeStack[stackTop[`HEAP_ID_WIDTH-1:0]] <= arrayId;
  end

endmodule

//--- hdl/heapMemory.sv
/*
  Array heap top: command controller, one bank per array and the result
  collector, one command per clock with a fixed one cycle latency
*/
`include "heapMemory_macros.svh"

module heapMemory import heapMemoryPkg::*; (
  input  logic      clock,
  input  logic      resetN,
  input  heapOpT    opcode,    // Non-Nop value is the command strobe
  input  arrayIdT   arrayId,
  input  indexT     index,
  input  dataT      dataIn,
  output dataT      dataOut,
  output heapErrorT error,
  output logic      done
);

  logic [`HEAP_ARRAY_COUNT-1:0] bankSelect;
  logic [`HEAP_ARRAY_COUNT-1:0] bankClear;
  arrayIdT                      selectedId;
  dataT                         allocId;
  heapErrorT                    ctrlFault;
  dataT                         bankResult [`HEAP_ARRAY_COUNT];
  heapErrorT                    bankFault  [`HEAP_ARRAY_COUNT];

  heapController i_controller (
    .clock, .resetN, .opcode, .arrayId,
    .bankSelect, .bankClear, .selectedId, .allocId, .ctrlFault
  );

  // ------------------------------
  // One bank per array
  for (genvar bank = 0; bank < `HEAP_ARRAY_COUNT; bank++) begin : g_bank
    arrayBank i_bank (
      .clock, .resetN,
      .select     (bankSelect[bank]),
      .clear      (bankClear[bank]),
      .opcode, .index, .dataIn,
      .bankResult (bankResult[bank]),
      .bankFault  (bankFault[bank])
    );
  end

  resultCollector i_collector (
    .clock, .resetN, .opcode, .selectedId,
    .bankResult, .bankFault, .allocId, .ctrlFault,
    .dataOut, .error, .done
  );

endmodule

//--- hdl/heapMemoryPkg.sv
/*
  Array heap types: command opcodes, error codes and word types
*/
`include "heapMemory_macros.svh"

package heapMemoryPkg;

  typedef enum logic [3:0] {
    Nop      = 4'd0,   // No command this cycle
    Alloc    = 4'd1,   // Allocate an array
    Free     = 4'd2,   // Release an array
    Write    = 4'd3,   // Store an element
    Read     = 4'd4,   // Fetch an element
    Size     = 4'd5,   // Current array size
    Push     = 4'd6,   // Append at the end
    Pop      = 4'd7,   // Remove from the end
    Add      = 4'd8,   // Returns new value
    AddAfter = 4'd9,   // Returns old value
    Subtract = 4'd10,  // Returns new value
    SubAfter = 4'd11,  // Returns old value
    Or       = 4'd12,
    Xor      = 4'd13,
    And      = 4'd14
  } heapOpT;

  typedef enum logic [2:0] {
    ErrNone         = 3'd0,
    ErrNotAllocated = 3'd1,  // Array not allocated, also double free
    ErrOutOfBounds  = 3'd2,  // Index at or beyond size
    ErrFull         = 3'd3,  // Push on full array
    ErrEmpty        = 3'd4,  // Pop on empty array
    ErrOutOfMemory  = 3'd5   // No array left to allocate
  } heapErrorT;

  typedef logic [`HEAP_DATA_WIDTH-1:0]  dataT;
  typedef logic [`HEAP_ID_WIDTH-1:0]    arrayIdT;
  typedef logic [`HEAP_INDEX_WIDTH-1:0] indexT;
  typedef logic [`HEAP_SIZE_WIDTH-1:0]  sizeT;

endpackage

//--- hdl/heapMemory_macros.svh
/*
  Array heap sizing: array count, elements per array and the widths
  derived from them
*/
`ifndef HEAP_MEMORY_MACROS_SVH
`define HEAP_MEMORY_MACROS_SVH

`define HEAP_ARRAY_COUNT   4   // Arrays in the heap
`define HEAP_ARRAY_LENGTH  8   // Elements per array
`define HEAP_DATA_WIDTH    16  // Element width
`define HEAP_ID_WIDTH      2   // Bits in an array number
`define HEAP_INDEX_WIDTH   3   // Bits in an element index

// One bit wider than an index so a full array fits
`define HEAP_SIZE_WIDTH    4

`endif

//--- hdl/resultCollector.sv
/*
  Result collector: picks the controller's or the selected bank's result
  and error, registers them and pulses done
*/
`include "heapMemory_macros.svh"

module resultCollector import heapMemoryPkg::*; (
  input  logic      clock,
  input  logic      resetN,
  input  heapOpT    opcode,
  input  arrayIdT   selectedId,
  input  dataT      bankResult [`HEAP_ARRAY_COUNT],
  input  heapErrorT bankFault  [`HEAP_ARRAY_COUNT],
  input  dataT      allocId,
  input  heapErrorT ctrlFault,
  output dataT      dataOut,
  output heapErrorT error,
  output logic      done
);

  dataT      resultData;
  heapErrorT resultFault;

  always_comb begin
    resultData  = '0;
    resultFault = ErrNone;
    if (ctrlFault != ErrNone) begin                 // Controller fault wins
      resultFault = ctrlFault;
    end else if (opcode == Alloc) begin
      resultData = allocId;
    end else if (opcode != Nop && opcode != Free) begin
      resultData  = bankResult[selectedId];
      resultFault = bankFault[selectedId];
    end
    if (resultFault != ErrNone) resultData = '0;    // No data with an error
  end

  // ------------------------------
  // One cycle result stage
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      dataOut <= '0;
      error   <= ErrNone;
      done    <= 1'b0;
    end else begin
      dataOut <= resultData;
      error   <= resultFault;
      done    <= opcode != Nop;                     // Any command completes
    end
  end

endmodule

//--- src.f
+incdir+hdl
hdl/heapMemoryPkg.sv
hdl/heapController.sv
hdl/arrayBank.sv
hdl/resultCollector.sv
hdl/heapMemory.sv
test/heapMemory_chk.sv
test/heapMemoryTb.sv

//--- test/heapMemoryTb.sv
/*
  Array heap testbench: builds a table of commands with expected results,
  applies it one command per cycle and checks dataOut, error and done
*/

module heapMemoryTb import heapMemoryPkg::*; ();

  logic      clock;
  logic      resetN;
  heapOpT    opcode;
  arrayIdT   arrayId;
  indexT     index;
  dataT      dataIn;
  dataT      dataOut;
  heapErrorT error;
  logic      done;

  // Stimulus table with one entry per command
  heapOpT    stepOp    [$];
  arrayIdT   stepId    [$];
  indexT     stepIndex [$];
  dataT      stepData  [$];
  dataT      expData   [$];
  heapErrorT expError  [$];

  int dataErrors  = 0;
  int faultErrors = 0;
  int doneErrors  = 0;
  int cycleCount  = 0;
  int cycleLimit  = 0;                        // Set once the table is built

  heapMemory i_dut (
    .clock, .resetN, .opcode, .arrayId, .index, .dataIn,
    .dataOut, .error, .done
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;               // Period 20
  end

  // ------------------------------
  // Run limit
  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic addStep(input heapOpT op, input arrayIdT id, input indexT idx,
                         input dataT data, input dataT expD, input heapErrorT expE);
    stepOp.push_back(op);
    stepId.push_back(id);
    stepIndex.push_back(idx);
    stepData.push_back(data);
    expData.push_back(expD);
    expError.push_back(expE);
  endtask

  // ------------------------------
  // Table of commands and expected results
  task automatic buildTable();
    dataT model;                              // Expected element value
    dataT operand;
    for (int i = 0; i < 4; i++) addStep(Alloc, 0, 0, 0, dataT'(i), ErrNone);
    addStep(Alloc, 0, 0, 0, 0, ErrOutOfMemory);  // All four in use
    addStep(Free, 2, 0, 0, 0, ErrNone);
    addStep(Free, 1, 0, 0, 0, ErrNone);
    addStep(Alloc, 0, 0, 0, 1, ErrNone);      // Last freed comes back first
    addStep(Alloc, 0, 0, 0, 2, ErrNone);
    // Double free and access after free
    addStep(Write, 3, 2, 16'h1234, 16'h1234, ErrNone);
    addStep(Size, 3, 0, 0, 3, ErrNone);
    addStep(Free, 3, 0, 0, 0, ErrNone);
    addStep(Free, 3, 0, 0, 0, ErrNotAllocated);
    addStep(Write, 3, 0, 16'h4321, 0, ErrNotAllocated);
    addStep(Alloc, 0, 0, 0, 3, ErrNone);
    addStep(Size, 3, 0, 0, 0, ErrNone);       // Reallocated array is empty
    // Write, read and size
    addStep(Write, 0, 3, 16'hBEEF, 16'hBEEF, ErrNone);
    addStep(Size, 0, 0, 0, 4, ErrNone);
    addStep(Read, 0, 3, 0, 16'hBEEF, ErrNone);
    addStep(Read, 0, 5, 0, 0, ErrOutOfBounds);
    // Stack on array 1
    for (int i = 0; i < 8; i++) addStep(Push, 1, 0, dataT'(16'h1100 + i), 0, ErrNone);
    addStep(Push, 1, 0, 16'h2222, 0, ErrFull);
    addStep(Size, 1, 0, 0, 8, ErrNone);
    for (int i = 7; i >= 0; i--) addStep(Pop, 1, 0, 0, dataT'(16'h1100 + i), ErrNone);
    addStep(Pop, 1, 0, 0, 0, ErrEmpty);
    // Arithmetic on element 0 of array 2
    model = 16'hFFF0;
    addStep(Write, 2, 0, model, model, ErrNone);
    operand = 16'h0020;
    model   = model + operand;                // Wraps past the top
    addStep(Add, 2, 0, operand, model, ErrNone);
    operand = 16'h0005;
    addStep(AddAfter, 2, 0, operand, model, ErrNone);  // Old value back
    model = model + operand;
    addStep(Read, 2, 0, 0, model, ErrNone);
    operand = 16'h0020;
    model   = model - operand;                // Wraps below zero
    addStep(Subtract, 2, 0, operand, model, ErrNone);
    operand = 16'h0005;
    addStep(SubAfter, 2, 0, operand, model, ErrNone);
    model = model - operand;
    addStep(Read, 2, 0, 0, model, ErrNone);
    // Bitwise on element 1 of array 2
    model = 16'h5A5A;
    addStep(Write, 2, 1, model, model, ErrNone);
    operand = 16'h0FF0;
    model   = model | operand;
    addStep(Or, 2, 1, operand, model, ErrNone);
    operand = 16'h00FF;
    model   = model ^ operand;
    addStep(Xor, 2, 1, operand, model, ErrNone);
    operand = 16'hF0F0;
    model   = model & operand;
    addStep(And, 2, 1, operand, model, ErrNone);
    addStep(Read, 2, 1, 0, model, ErrNone);
  endtask

  task automatic checkStep(input int n);
    if (done !== 1'b1) begin
      $display("Step %0d (%s): done did not pulse after the command", n, stepOp[n].name());
      doneErrors++;
    end
    if (dataOut !== expData[n]) begin
      $display("ERROR %0t: step %0d (%s) dataOut %h, expected %h",
               $time, n, stepOp[n].name(), dataOut, expData[n]);
      dataErrors++;
    end
    if (error !== expError[n]) begin
      $display("ERROR %0t: step %0d (%s) error %s, expected %s",
               $time, n, stepOp[n].name(), error.name(), expError[n].name());
      faultErrors++;
    end
  endtask

  // ------------------------------
  // Main sequence
  initial begin
    opcode  = Nop;
    arrayId = '0;
    index   = '0;
    dataIn  = '0;
    resetN  = 1'b0;
    buildTable();
    cycleLimit = stepOp.size() * 2 + 8 + 20;
    repeat (8) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    if (done !== 1'b0 || dataOut !== '0 || error !== ErrNone) begin
      $display("ERROR %0t: outputs not cleared by reset", $time);
      doneErrors++;
    end
    for (int n = 0; n < stepOp.size(); n++) begin
      opcode  = stepOp[n];                    // Driven on the falling edge
      arrayId = stepId[n];
      index   = stepIndex[n];
      dataIn  = stepData[n];
      @(posedge clock);
      @(negedge clock);
      checkStep(n);
    end
    opcode = Nop;
    dataIn = '0;
    repeat (2) @(posedge clock);              // Second edge sees done after the Nop
    @(negedge clock);
    if (done !== 1'b0) begin
      $display("Done stayed high after a Nop cycle");
      doneErrors++;
    end
    $display("Errors: dataOut %0d, error code %0d, done %0d",
             dataErrors, faultErrors, doneErrors);
    if (dataErrors + faultErrors + doneErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- test/heapMemory_chk.sv
/*
  Array heap protocol checks: done follows each command by one cycle
  and error stays clear outside a done pulse
*/

module heapMemory_chk import heapMemoryPkg::*; (
  input logic      clock,
  input logic      resetN,
  input heapOpT    opcode,
  input logic      done,
  input heapErrorT error
);

  // Command gives done next cycle
  doneAfterCommand: assert property (@(posedge clock) disable iff (!resetN)
    opcode != Nop |=> done)
    else $error("done missing one cycle after a command");

  // Nop never completes
  noDoneWithoutCommand: assert property (@(posedge clock) disable iff (!resetN)
    opcode == Nop |=> !done)
    else $error("done raised without a command");

  errorOnlyWithDone: assert property (@(posedge clock) disable iff (!resetN)
    !done |-> error == ErrNone)
    else $error("error code set while done is low");

endmodule

bind heapMemory heapMemory_chk i_chk (.clock, .resetN, .opcode, .done, .error);
